//--- hw/cw_pkg.sv
package cw_pkg;

   // Register map, 6-bit address space
   typedef enum logic [5:0] {
      REG_NONE          = 6'h00,  // Idle bus address
      REG_TRIG_CFG      = 6'h01,
      REG_TRIG_COUNT    = 6'h02,  // Read only
      REG_GLITCH_OFFSET = 6'h03,
      REG_GLITCH_WIDTH  = 6'h04,
      REG_GLITCH_CTRL   = 6'h05,  // Bit 0 is arm
      REG_IO_CTRL       = 6'h06
   } reg_addr_e;

   // Internal register bus, one access per cycle
   typedef struct packed {
      reg_addr_e   addr;
      logic [7:0]  wdata;
      logic        wr;   // Single-cycle write strobe
      logic        rd;   // Single-cycle read strobe
   } reg_bus_t;

   // Pin combine mode
   typedef enum logic [1:0] {
      TRIG_OR  = 2'b00,
      TRIG_AND = 2'b01
   } trig_mode_e;

   typedef struct packed {
      logic [1:0]  spare;
      trig_mode_e  mode;
      logic [3:0]  mask;  // Bit 0 is io1
   } trig_cfg_t;

   typedef struct packed {
      logic [3:0]  spare;
      logic        power_off;   // Drives target_npower
      logic        nrst_val;
      logic        nrst_en;
      logic        avrprog_en;  // Hand programming lines to host SPI
   } io_ctrl_t;

   typedef enum logic [1:0] {GL_IDLE, GL_DELAY, GL_PULSE} glitch_state_e;

endpackage

//--- hw/usb_reg_bridge.sv
`timescale 1ns/1ps

module usb_reg_bridge (
   input  logic              clk_usb_buf,
   input  logic              rst_n_i,
   input  cw_pkg::reg_addr_e host_addr_i,
   input  logic [7:0]        host_wdata_i,
   input  logic              host_wr_i,
   input  logic              host_rd_i,
   input  logic [7:0]        rdata_i,     // OR of all block read data
   output cw_pkg::reg_bus_t  reg_bus_o,
   output logic [7:0]        host_rdata_o,
   output logic              host_rvalid_o
);
   import cw_pkg::*;

   reg_addr_e   addr_q;
   logic [7:0]  wdata_q;
   logic        wr_q;
   logic        rd_q;
   logic [7:0]  rdata_q;
   logic        rvalid_q;
   logic        access;

   assign access = host_wr_i | host_rd_i;

   // Address and data only move on an access
   always_ff @(posedge clk_usb_buf) begin
      if (access) begin
         addr_q  <= host_addr_i;
         wdata_q <= host_wdata_i;
      end
   end

   // Strobes last exactly one cycle on the bus
   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         wr_q <= 1'b0;
         rd_q <= 1'b0;
      end else begin
         wr_q <= host_wr_i;
         rd_q <= host_rd_i;
      end
   end

   assign reg_bus_o.addr  = addr_q;
   assign reg_bus_o.wdata = wdata_q;
   assign reg_bus_o.wr    = wr_q;
   assign reg_bus_o.rd    = rd_q;

   // Read data sampled while bus read strobe is up
   always_ff @(posedge clk_usb_buf) begin
      if (rd_q) rdata_q <= rdata_i;
   end

   // Valid is the bus read strobe one cycle later
   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) rvalid_q <= 1'b0;
      else          rvalid_q <= rd_q;
   end

   assign host_rdata_o  = rdata_q;
   assign host_rvalid_o = rvalid_q;

endmodule

//--- hw/reg_trigger.sv
`timescale 1ns/1ps

module reg_trigger #(
   parameter int unsigned TRIG_SYNC_STAGES = 2
) (
   input  logic             clk_usb_buf,
   input  logic             rst_n_i,
   input  cw_pkg::reg_bus_t reg_bus_i,
   input  logic [3:0]       target_io_i,  // Async target pins io1..io4
   output logic [7:0]       rdata_o,
   output logic             trig_o
);
   import cw_pkg::*;

   trig_cfg_t   cfg_q;
   logic [3:0]  sync_q [TRIG_SYNC_STAGES];
   logic [3:0]  pins;
   logic [3:0]  masked;
   logic        combined;
   logic        trig_q;
   logic        trig_d1_q;   // Previous trig for edge detect
   logic [7:0]  count_q;
   logic        cfg_wr;

   assign cfg_wr = reg_bus_i.wr && (reg_bus_i.addr == REG_TRIG_CFG);

   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i)    cfg_q <= '0;
      else if (cfg_wr) cfg_q <= trig_cfg_t'(reg_bus_i.wdata);
   end

   // Pin synchronizer chain
   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         for (int i = 0; i < TRIG_SYNC_STAGES; i++) sync_q[i] <= 4'b0;
      end else begin
         sync_q[0] <= target_io_i;
         for (int i = 1; i < TRIG_SYNC_STAGES; i++) sync_q[i] <= sync_q[i-1];
      end
   end

   assign pins   = sync_q[TRIG_SYNC_STAGES-1];
   assign masked = pins & cfg_q.mask;

   // AND needs every masked pin; empty mask never triggers
   always_comb begin
      if (cfg_q.mode == TRIG_AND)
         combined = (cfg_q.mask != 4'b0) && (masked == cfg_q.mask);
      else
         combined = |masked;  // Unused mode codes act as OR
   end

   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         trig_q    <= 1'b0;
         trig_d1_q <= 1'b0;
      end else begin
         trig_q    <= combined;
         trig_d1_q <= trig_q;
      end
   end

   // Rising-edge counter, saturates at 255
   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i || cfg_wr)
         count_q <= 8'd0;
      else if (trig_q && !trig_d1_q && count_q != 8'hff)
         count_q <= count_q + 8'd1;
   end

   always_comb begin
      case (reg_bus_i.addr)
         REG_TRIG_CFG:   rdata_o = cfg_q;
         REG_TRIG_COUNT: rdata_o = count_q;
         default:        rdata_o = 8'd0;
      endcase
   end

   assign trig_o = trig_q;

endmodule

//--- hw/reg_glitch.sv
`timescale 1ns/1ps

module reg_glitch (
   input  logic             clk_usb_buf,
   input  logic             rst_n_i,
   input  cw_pkg::reg_bus_t reg_bus_i,
   input  logic             trig_i,
   output logic [7:0]       rdata_o,
   output logic             glitch_o
);
   import cw_pkg::*;

   logic [7:0]     offset_q;
   logic [7:0]     width_q;
   logic           arm_q;
   logic           trig_prev_q;
   logic           trig_rise;
   glitch_state_e  state_q, state_d;
   logic [7:0]     cnt_q, cnt_d;   // Cycles left in current phase, minus one
   logic           pulse_done;
   logic           glitch_q;

   // Config registers
   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         offset_q <= 8'd0;
         width_q  <= 8'd0;
      end else if (reg_bus_i.wr) begin
         if (reg_bus_i.addr == REG_GLITCH_OFFSET) offset_q <= reg_bus_i.wdata;
         if (reg_bus_i.addr == REG_GLITCH_WIDTH)  width_q  <= reg_bus_i.wdata;
      end
   end

   // Arm is one-shot, dropped when the pulse finishes
   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i)
         arm_q <= 1'b0;
      else if (reg_bus_i.wr && reg_bus_i.addr == REG_GLITCH_CTRL)
         arm_q <= reg_bus_i.wdata[0];
      else if (pulse_done)
         arm_q <= 1'b0;
   end

   assign trig_rise = trig_i && !trig_prev_q;

   always_comb begin
      state_d    = state_q;
      cnt_d      = cnt_q;
      pulse_done = 1'b0;
      case (state_q)
         GL_IDLE: begin
            // Zero width never fires, arm stays set
            if (trig_rise && arm_q && width_q != 8'd0) begin
               if (offset_q == 8'd0) begin
                  state_d = GL_PULSE;
                  cnt_d   = width_q - 8'd1;
               end else begin
                  state_d = GL_DELAY;
                  cnt_d   = offset_q - 8'd1;
               end
            end
         end
         GL_DELAY: begin
            if (cnt_q == 8'd0) begin
               state_d = GL_PULSE;
               cnt_d   = width_q - 8'd1;
            end else begin
               cnt_d = cnt_q - 8'd1;
            end
         end
         GL_PULSE: begin
            if (cnt_q == 8'd0) begin
               state_d    = GL_IDLE;
               pulse_done = 1'b1;
            end else begin
               cnt_d = cnt_q - 8'd1;
            end
         end
         default: state_d = GL_IDLE;
      endcase
   end

   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         state_q     <= GL_IDLE;
         cnt_q       <= 8'd0;
         trig_prev_q <= 1'b0;
         glitch_q    <= 1'b0;
      end else begin
         state_q     <= state_d;
         cnt_q       <= cnt_d;
         trig_prev_q <= trig_i;
         glitch_q    <= (state_d == GL_PULSE);  // Registered, no decode glitches
      end
   end

   always_comb begin
      case (reg_bus_i.addr)
         REG_GLITCH_OFFSET: rdata_o = offset_q;
         REG_GLITCH_WIDTH:  rdata_o = width_q;
         REG_GLITCH_CTRL:   rdata_o = {7'd0, arm_q};  // Live arm state
         default:           rdata_o = 8'd0;
      endcase
   end

   assign glitch_o = glitch_q;

endmodule

//--- hw/target_io_mux.sv
`timescale 1ns/1ps

module target_io_mux (
   input  logic             clk_usb_buf,
   input  logic             rst_n_i,
   input  cw_pkg::reg_bus_t reg_bus_i,
   input  logic             spi_mosi_i,     // Host programming SPI
   input  logic             spi_sck_i,
   input  logic             treset_i,
   input  logic             target_miso_i,
   input  logic             ext_miso_i,     // External header MISO
   output logic [7:0]       rdata_o,
   output logic             target_nrst_o,
   output logic             target_nrst_oe_o,
   output logic             target_mosi_o,
   output logic             target_mosi_oe_o,
   output logic             target_sck_o,
   output logic             target_sck_oe_o,
   output logic             spi_miso_o,
   output logic             target_npower_o
);
   import cw_pkg::*;

   io_ctrl_t  io_q;
   logic      drive_ok;  // Pads float while target is unpowered

   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i)
         io_q <= '0;
      else if (reg_bus_i.wr && reg_bus_i.addr == REG_IO_CTRL)
         io_q <= io_ctrl_t'(reg_bus_i.wdata);
   end

   assign drive_ok        = !io_q.power_off;
   assign target_npower_o = io_q.power_off;

   // Programmer owns nRST, else the register bits
   assign target_nrst_o    = io_q.avrprog_en ? treset_i : io_q.nrst_val;
   assign target_nrst_oe_o = drive_ok && (io_q.avrprog_en || io_q.nrst_en);

   assign target_mosi_o    = io_q.avrprog_en && spi_mosi_i;
   assign target_mosi_oe_o = drive_ok && io_q.avrprog_en;
   assign target_sck_o     = io_q.avrprog_en && spi_sck_i;
   assign target_sck_oe_o  = drive_ok && io_q.avrprog_en;

   assign spi_miso_o = io_q.avrprog_en ? target_miso_i : ext_miso_i;

   assign rdata_o = (reg_bus_i.addr == REG_IO_CTRL) ? io_q : 8'd0;

endmodule

//--- hw/cw_core_top.sv
`timescale 1ns/1ps

module cw_core_top #(
   parameter int unsigned TRIG_SYNC_STAGES = 2  // Flops per trigger pin
) (
   input  logic              clk_usb_buf,
   input  logic              rst_n_i,
   input  cw_pkg::reg_addr_e host_addr_i,
   input  logic [7:0]        host_wdata_i,
   input  logic              host_wr_i,
   input  logic              host_rd_i,
   input  logic [3:0]        target_io_i,
   input  logic              spi_mosi_i,
   input  logic              spi_sck_i,
   input  logic              treset_i,
   input  logic              target_miso_i,
   input  logic              ext_miso_i,
   output logic [7:0]        host_rdata_o,
   output logic              host_rvalid_o,
   output logic              trigger_out_o,
   output logic              glitch_o,
   output logic              target_nrst_o,
   output logic              target_nrst_oe_o,
   output logic              target_mosi_o,
   output logic              target_mosi_oe_o,
   output logic              target_sck_o,
   output logic              target_sck_oe_o,
   output logic              spi_miso_o,
   output logic              target_npower_o
);
   import cw_pkg::*;

   reg_bus_t    reg_bus;
   logic [7:0]  rdata_trig, rdata_glitch, rdata_io;
   logic [7:0]  rdata_all;
   logic        trig;

   assign rdata_all     = rdata_trig | rdata_glitch | rdata_io;  // Unselected blocks give 0
   assign trigger_out_o = trig;

   usb_reg_bridge u_bridge (
      .clk_usb_buf   (clk_usb_buf),
      .rst_n_i       (rst_n_i),
      .host_addr_i   (host_addr_i),
      .host_wdata_i  (host_wdata_i),
      .host_wr_i     (host_wr_i),
      .host_rd_i     (host_rd_i),
      .rdata_i       (rdata_all),
      .reg_bus_o     (reg_bus),
      .host_rdata_o  (host_rdata_o),
      .host_rvalid_o (host_rvalid_o)
   );

   reg_trigger #(
      .TRIG_SYNC_STAGES (TRIG_SYNC_STAGES)
   ) u_trigger (
      .clk_usb_buf (clk_usb_buf),
      .rst_n_i     (rst_n_i),
      .reg_bus_i   (reg_bus),
      .target_io_i (target_io_i),
      .rdata_o     (rdata_trig),
      .trig_o      (trig)
   );

   reg_glitch u_glitch (
      .clk_usb_buf (clk_usb_buf),
      .rst_n_i     (rst_n_i),
      .reg_bus_i   (reg_bus),
      .trig_i      (trig),
      .rdata_o     (rdata_glitch),
      .glitch_o    (glitch_o)
   );

   target_io_mux u_io_mux (
      .clk_usb_buf      (clk_usb_buf),
      .rst_n_i          (rst_n_i),
      .reg_bus_i        (reg_bus),
      .spi_mosi_i       (spi_mosi_i),
      .spi_sck_i        (spi_sck_i),
      .treset_i         (treset_i),
      .target_miso_i    (target_miso_i),
      .ext_miso_i       (ext_miso_i),
      .rdata_o          (rdata_io),
      .target_nrst_o    (target_nrst_o),
      .target_nrst_oe_o (target_nrst_oe_o),
      .target_mosi_o    (target_mosi_o),
      .target_mosi_oe_o (target_mosi_oe_o),
      .target_sck_o     (target_sck_o),
      .target_sck_oe_o  (target_sck_oe_o),
      .spi_miso_o       (spi_miso_o),
      .target_npower_o  (target_npower_o)
   );

endmodule

//--- tests/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
   parameter int HALF_PERIOD_NS = 10,  // 20 ns clock
   parameter int RST_CYCLES     = 10
) (
   output logic clk_usb_buf,
   output logic rst_n_o
);

   initial begin
      clk_usb_buf = 1'b0;
      forever #HALF_PERIOD_NS clk_usb_buf = ~clk_usb_buf;
   end

   // Release lands 1 ns after an edge, same as stimulus
   initial begin
      rst_n_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_usb_buf);
      #1;
      rst_n_o = 1'b1;
   end

endmodule

//--- tests/cw_core_asserts.sv
`timescale 1ns/1ps

module cw_core_asserts (
   input logic                  clk_usb_buf,
   input logic                  rst_n_i,
   input logic                  host_rd_i,
   input logic                  host_rvalid_i,
   input logic                  glitch_i,
   input cw_pkg::glitch_state_e gl_state_i,   // Glitch FSM state
   input logic                  target_npower_i,
   input logic                  nrst_oe_i,
   input logic                  mosi_oe_i,
   input logic                  sck_oe_i
);
   import cw_pkg::*;

   // Read latency through the bridge, both directions
   rvalid_after_rd: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      host_rd_i |-> ##2 host_rvalid_i)
      else $error("host_rvalid_o missing 2 cycles after host_rd_i");

   rvalid_has_rd: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      host_rvalid_i |-> $past(host_rd_i, 2))
      else $error("host_rvalid_o without host_rd_i 2 cycles before");

   glitch_not_idle: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      $rose(glitch_i) |-> gl_state_i != GL_IDLE)
      else $error("glitch_o rose while glitch FSM idle");

   // Unpowered target must see floating pads
   float_when_off: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      target_npower_i |-> !(nrst_oe_i || mosi_oe_i || sck_oe_i))
      else $error("Output enable high with target power off");

endmodule

bind cw_core_top cw_core_asserts u_asserts (
   .clk_usb_buf     (clk_usb_buf),
   .rst_n_i         (rst_n_i),
   .host_rd_i       (host_rd_i),
   .host_rvalid_i   (host_rvalid_o),
   .glitch_i        (glitch_o),
   .gl_state_i      (u_glitch.state_q),
   .target_npower_i (target_npower_o),
   .nrst_oe_i       (target_nrst_oe_o),
   .mosi_oe_i       (target_mosi_oe_o),
   .sck_oe_i        (target_sck_oe_o)
);

//--- tests/tb_cw_core.sv
`timescale 1ns/1ps

module tb_cw_core;
   import cw_pkg::*;

   localparam int RST_TIMEOUT    = 40;
   localparam int RVALID_TIMEOUT = 8;    // Bridge answers in 2
   localparam int GLITCH_TIMEOUT = 300;

   logic        clk_usb_buf;
   logic        rst_n;
   reg_addr_e   host_addr;
   logic [7:0]  host_wdata;
   logic        host_wr, host_rd;
   logic [3:0]  target_io;
   logic        spi_mosi, spi_sck, treset, target_miso, ext_miso;
   logic [7:0]  host_rdata;
   logic        host_rvalid, trigger_out, glitch;
   logic        nrst, nrst_oe, mosi, mosi_oe, sck, sck_oe, spi_miso, npower;
   int          checks;
   int          value_errs;
   int          timeouts;

   tb_clkgen u_clkgen (.clk_usb_buf(clk_usb_buf), .rst_n_o(rst_n));

   cw_core_top #(.TRIG_SYNC_STAGES(2)) dut (
      .clk_usb_buf      (clk_usb_buf),
      .rst_n_i          (rst_n),
      .host_addr_i      (host_addr),
      .host_wdata_i     (host_wdata),
      .host_wr_i        (host_wr),
      .host_rd_i        (host_rd),
      .target_io_i      (target_io),
      .spi_mosi_i       (spi_mosi),
      .spi_sck_i        (spi_sck),
      .treset_i         (treset),
      .target_miso_i    (target_miso),
      .ext_miso_i       (ext_miso),
      .host_rdata_o     (host_rdata),
      .host_rvalid_o    (host_rvalid),
      .trigger_out_o    (trigger_out),
      .glitch_o         (glitch),
      .target_nrst_o    (nrst),
      .target_nrst_oe_o (nrst_oe),
      .target_mosi_o    (mosi),
      .target_mosi_oe_o (mosi_oe),
      .target_sck_o     (sck),
      .target_sck_oe_o  (sck_oe),
      .spi_miso_o       (spi_miso),
      .target_npower_o  (npower)
   );

   // One edge later, plus drive skew
   task automatic next_cycle();
      @(posedge clk_usb_buf);
      #1;
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) next_cycle();
   endtask

   task automatic check_reg(input string name, input logic [7:0] exp, input logic [7:0] act);
      checks++;
      if (act !== exp) begin
         value_errs++;
         $display("CHECK FAILED at %0t: %s expected 0x%02h, got 0x%02h", $time, name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         value_errs++;
         $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
      end
   endtask

   task automatic check_cycles(input string name, input int exp, input int act);
      checks++;
      if (act != exp) begin
         value_errs++;
         $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      end
   endtask

   task automatic check_enables(input logic exp_nrst_oe, input logic exp_mosi_oe,
                                input logic exp_sck_oe, input logic exp_npower);
      check_bit("target_nrst_oe_o", exp_nrst_oe, nrst_oe);
      check_bit("target_mosi_oe_o", exp_mosi_oe, mosi_oe);
      check_bit("target_sck_oe_o", exp_sck_oe, sck_oe);
      check_bit("target_npower_o", exp_npower, npower);
   endtask

   // Strobe cycle, bus cycle, then register holds the value
   task automatic host_write(input reg_addr_e addr, input logic [7:0] data);
      next_cycle();
      host_addr  = addr;
      host_wdata = data;
      host_wr    = 1'b1;
      next_cycle();
      host_wr = 1'b0;
      next_cycle();
   endtask

   task automatic host_read(input reg_addr_e addr, output logic [7:0] data);
      int waited;
      next_cycle();
      host_addr = addr;
      host_rd   = 1'b1;
      next_cycle();
      host_rd = 1'b0;
      waited  = 0;
      while (host_rvalid !== 1'b1 && waited < RVALID_TIMEOUT) begin
         next_cycle();
         waited++;
      end
      if (host_rvalid !== 1'b1) begin
         $display("TIMEOUT: no host_rvalid_o after read of %s", addr.name());
         timeouts++;
         data = 'x;
      end else begin
         data = host_rdata;
      end
   endtask

   // OR needs one masked pin high, AND needs all, empty mask never fires
   function automatic logic expected_trigger(input logic [3:0] mask, input trig_mode_e mode,
                                             input logic [3:0] pins);
      logic any_hit;
      logic all_hit;
      any_hit = 1'b0;
      all_hit = 1'b1;
      for (int i = 0; i < 4; i++) begin
         if (mask[i] && pins[i]) any_hit = 1'b1;
         if (mask[i] && !pins[i]) all_hit = 1'b0;
      end
      if (mask == 4'h0) return 1'b0;
      if (mode == TRIG_AND) return all_hit;
      return any_hit;
   endfunction

   task automatic write_readback(input reg_addr_e addr);
      logic [7:0] wval;
      logic [7:0] rval;
      wval = 8'($urandom);
      host_write(addr, wval);
      host_read(addr, rval);
      check_reg(addr.name(), wval, rval);
   endtask

   task automatic test_reset_readback();
      logic [7:0] rval;
      check_bit("host_rvalid_o", 1'b0, host_rvalid);
      check_bit("glitch_o", 1'b0, glitch);
      check_bit("trigger_out_o", 1'b0, trigger_out);
      check_enables(1'b0, 1'b0, 1'b0, 1'b0);
      for (int a = 1; a <= 6; a++) begin
         host_read(reg_addr_e'(6'(a)), rval);
         check_reg($sformatf("register 0x%02h after reset", a), 8'h00, rval);
      end
      write_readback(REG_TRIG_CFG);
      write_readback(REG_GLITCH_OFFSET);
      write_readback(REG_GLITCH_WIDTH);
      write_readback(REG_IO_CTRL);
      host_read(reg_addr_e'(6'h2a), rval);
      check_reg("unused register 0x2a", 8'h00, rval);
      host_write(REG_IO_CTRL, 8'h00);  // Powered, nothing driven
   endtask

   task automatic test_trigger_combine();
      trig_cfg_t cfg;
      for (int i = 0; i < 16; i++) begin
         cfg.spare = 2'b00;
         if (i % 2 == 1) cfg.mode = TRIG_AND;
         else            cfg.mode = TRIG_OR;
         cfg.mask = (i < 2) ? 4'h0 : 4'($urandom);  // First pair with empty mask
         host_write(REG_TRIG_CFG, cfg);
         target_io = 4'($urandom);
         wait_cycles(4);  // Sync, sync, combine, margin
         check_bit($sformatf("trigger_out_o mask %b %s io %b", cfg.mask, cfg.mode.name(),
                             target_io),
                   expected_trigger(cfg.mask, cfg.mode, target_io), trigger_out);
      end
   endtask

   task automatic test_trigger_count();
      trig_cfg_t  cfg;
      int         pin;
      int         n_edges;
      logic [7:0] rval;
      pin       = int'($urandom % 4);
      n_edges   = 3 + int'($urandom % 8);
      target_io = 4'h0;
      wait_cycles(4);  // Drain old levels before clearing
      cfg.spare = 2'b00;
      cfg.mode  = TRIG_OR;
      cfg.mask  = 4'(1 << pin);
      host_write(REG_TRIG_CFG, cfg);
      for (int i = 0; i < n_edges; i++) begin
         target_io = 4'(1 << pin);
         wait_cycles(3);
         target_io = 4'h0;
         wait_cycles(3);
      end
      wait_cycles(4);
      host_read(REG_TRIG_COUNT, rval);
      check_reg("trigger count", 8'(n_edges), rval);
      host_write(REG_TRIG_CFG, cfg);  // Any config write clears it
      host_read(REG_TRIG_COUNT, rval);
      check_reg("trigger count after cfg write", 8'h00, rval);
   endtask

   task automatic test_glitch_timing();
      trig_cfg_t  cfg;
      int         offset;
      int         width;
      int         waited;
      int         high_cycles;
      int         stray;
      logic [7:0] rval;
      offset    = int'($urandom % 10);
      width     = 1 + int'($urandom % 8);
      target_io = 4'h0;
      cfg.spare = 2'b00;
      cfg.mode  = TRIG_OR;
      cfg.mask  = 4'b0001;
      host_write(REG_TRIG_CFG, cfg);
      host_write(REG_GLITCH_OFFSET, 8'(offset));
      host_write(REG_GLITCH_WIDTH, 8'(width));
      host_write(REG_GLITCH_CTRL, 8'h01);
      host_read(REG_GLITCH_CTRL, rval);
      check_reg("glitch arm", 8'h01, rval);
      next_cycle();
      target_io = 4'b0001;  // Pin change is cycle 0
      waited    = 0;
      while (glitch !== 1'b1 && waited < GLITCH_TIMEOUT) begin
         next_cycle();
         waited++;
      end
      if (glitch !== 1'b1) begin
         $display("TIMEOUT: glitch_o never rose after the trigger");
         timeouts++;
      end else begin
         check_cycles("glitch_o delay", offset + 4, waited);  // 2 sync + combine + offset + 1
         high_cycles = 0;
         while (glitch === 1'b1 && high_cycles < GLITCH_TIMEOUT) begin
            next_cycle();
            high_cycles++;
         end
         if (glitch === 1'b1) begin
            $display("TIMEOUT: glitch_o stuck high");
            timeouts++;
         end else begin
            check_cycles("glitch_o width", width, high_cycles);
         end
      end
      host_read(REG_GLITCH_CTRL, rval);
      check_reg("glitch arm after pulse", 8'h00, rval);
      target_io = 4'h0;
      wait_cycles(4);
      target_io = 4'b0001;  // Second trigger, now disarmed
      stray     = 0;
      for (int i = 0; i < offset + width + 8; i++) begin
         next_cycle();
         if (glitch === 1'b1) stray++;
      end
      check_cycles("glitch_o high cycles while disarmed", 0, stray);
      target_io = 4'h0;
   endtask

   task automatic test_io_mux();
      io_ctrl_t ctrl;
      ctrl            = '0;
      ctrl.avrprog_en = 1'b1;
      host_write(REG_IO_CTRL, ctrl);
      for (int i = 0; i < 6; i++) begin
         {spi_mosi, spi_sck, treset, target_miso, ext_miso} = 5'($urandom);
         next_cycle();  // Mux path is combinational
         check_bit("target_nrst_o", treset, nrst);
         check_bit("target_mosi_o", spi_mosi, mosi);
         check_bit("target_sck_o", spi_sck, sck);
         check_bit("spi_miso_o", target_miso, spi_miso);
         check_enables(1'b1, 1'b1, 1'b1, 1'b0);
      end
      for (int k = 0; k < 4; k++) begin
         ctrl          = '0;
         ctrl.nrst_en  = 1'(k & 1);
         ctrl.nrst_val = 1'(k >> 1);
         host_write(REG_IO_CTRL, ctrl);
         {spi_mosi, spi_sck, treset, target_miso, ext_miso} = 5'($urandom);
         next_cycle();
         if (ctrl.nrst_en) check_bit("target_nrst_o", ctrl.nrst_val, nrst);
         check_bit("spi_miso_o", ext_miso, spi_miso);
         check_enables(ctrl.nrst_en, 1'b0, 1'b0, 1'b0);
      end
      ctrl.avrprog_en = 1'b1;  // Everything asks to drive, power off wins
      ctrl.nrst_en    = 1'b1;
      ctrl.power_off  = 1'b1;
      host_write(REG_IO_CTRL, ctrl);
      check_enables(1'b0, 1'b0, 1'b0, 1'b1);
      host_write(REG_IO_CTRL, 8'h00);
      check_enables(1'b0, 1'b0, 1'b0, 1'b0);
   endtask

   initial begin
      int waited;
      void'($urandom(47408));
      host_addr   = REG_NONE;
      host_wdata  = 8'h00;
      host_wr     = 1'b0;
      host_rd     = 1'b0;
      target_io   = 4'h0;
      spi_mosi    = 1'b0;
      spi_sck     = 1'b0;
      treset      = 1'b0;
      target_miso = 1'b0;
      ext_miso    = 1'b0;
      checks      = 0;
      value_errs  = 0;
      timeouts    = 0;
      waited      = 0;
      while (rst_n !== 1'b1 && waited < RST_TIMEOUT) begin
         next_cycle();
         waited++;
      end
      if (rst_n !== 1'b1) begin
         $display("TIMEOUT: reset was never released");
         timeouts++;
      end
      next_cycle();
      test_reset_readback();
      test_trigger_combine();
      test_trigger_count();
      test_glitch_timing();
      test_io_mux();
      $display("Checks: %0d, value errors: %0d, timeouts: %0d", checks, value_errs, timeouts);
      if (value_errs == 0 && timeouts == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

//--- all.f
hw/cw_pkg.sv
hw/usb_reg_bridge.sv
hw/reg_trigger.sv
hw/reg_glitch.sv
hw/target_io_mux.sv
hw/cw_core_top.sv
tests/tb_clkgen.sv
tests/cw_core_asserts.sv
tests/tb_cw_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the cw_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_cw_core -o tb_cw_core \
   > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Verilator build failed, see build.log"
   exit 1
fi

./obj_dir/tb_cw_core > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -qF '*** FAILED ***' sim.log; then
   exit 1
fi
exit 0
